// File: common/raster_macros.svh
`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// visible screen
`define SCREEN_W     16
`define SCREEN_H     12

// raster totals including blanking
`define LINE_TOTAL   24
`define FRAME_LINES  16

// framebuffer geometry
`define FB_DEPTH     (`SCREEN_W * `SCREEN_H)
`define FB_AW        8
`define COORD_W      5

// clear values
`define DEPTH_FAR    255
`define BG_INDEX     0

`endif

// File: common/raster_pkg.sv
package raster_pkg;

    `include "raster_macros.svh"

    // one screen vertex
    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } vertex_t;

    // flat shaded triangle, depth constant over the face
    typedef struct packed {
        vertex_t    v0;
        vertex_t    v1;
        vertex_t    v2;
        logic [7:0] depth;
        logic [3:0] color;  // palette index
    } tri_t;

    // one framebuffer word
    typedef struct packed {
        logic [7:0] depth;
        logic [3:0] color;
    } fb_word_t;

    // request toward the framebuffer port
    typedef struct packed {
        logic              valid;
        logic              write;  // low for a read
        logic [`FB_AW-1:0] addr;
        fb_word_t          data;
    } fb_req_t;

endpackage

// File: logic/framebuffer_ram.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module framebuffer_ram (
    input  logic                 clk_pix,
    input  raster_pkg::fb_req_t  i_req,
    output raster_pkg::fb_word_t o_rdata
);

    // depth and colour index per pixel
    raster_pkg::fb_word_t mem [`FB_DEPTH];

    always_ff @(posedge clk_pix) begin
        if (i_req.valid && i_req.write) begin
            mem[i_req.addr] <= i_req.data;
        end
    end

    // read data lands one cycle after the granted read
    always_ff @(posedge clk_pix) begin
        if (i_req.valid && !i_req.write) begin
            o_rdata <= mem[i_req.addr];
        end
    end

endmodule

// File: logic/fb_arbiter.sv
`timescale 1ns/10ps

module fb_arbiter (
    input  logic                clk_pix,
    input  logic                i_rst_n,
    input  raster_pkg::fb_req_t i_d_req,
    input  raster_pkg::fb_req_t i_r_req,
    output raster_pkg::fb_req_t o_mem_req,
    output logic                o_d_gnt,
    output logic                o_r_gnt
);

    // display wins every cycle it asks
    assign o_d_gnt = i_d_req.valid;
    assign o_r_gnt = i_r_req.valid && !i_d_req.valid;

    always_comb begin
        if (i_d_req.valid) begin
            o_mem_req = i_d_req;
        end else begin
            o_mem_req = i_r_req;  // idle when neither asks, valid stays low
        end
    end

endmodule

// File: raster/tri_rasterizer.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module tri_rasterizer (
    input  logic                 clk_pix,
    input  logic                 i_rst_n,
    input  raster_pkg::tri_t     i_tri,
    input  logic                 i_tri_valid,
    input  logic                 i_clear,
    input  logic                 i_gnt,
    input  raster_pkg::fb_word_t i_rdata,
    output raster_pkg::fb_req_t  o_req,
    output logic                 o_busy,
    output logic                 o_done
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_CLEAR, ST_SCAN, ST_READ, ST_CMP, ST_WRITE
    } state_t;

    state_t               state;
    raster_pkg::tri_t     tri_q;
    logic [`COORD_W-1:0]  xmin, xmax, ymax;
    logic [`COORD_W-1:0]  px, py;    // current pixel in the box
    logic [`FB_AW-1:0]    clr_addr;
    logic signed [11:0]   e0, e1, e2;
    logic                 covered;
    logic                 last_px;
    logic                 step;      // leave the current pixel
    logic                 start_clr, start_tri;

    function automatic logic [`COORD_W-1:0] lo3(input logic [`COORD_W-1:0] a,
                                                 input logic [`COORD_W-1:0] b,
                                                 input logic [`COORD_W-1:0] c);
        logic [`COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic [`COORD_W-1:0] hi3(input logic [`COORD_W-1:0] a,
                                                 input logic [`COORD_W-1:0] b,
                                                 input logic [`COORD_W-1:0] c);
        logic [`COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // keep the box on screen
    function automatic logic [`COORD_W-1:0] clip(input logic [`COORD_W-1:0] v,
                                                  input logic [`COORD_W-1:0] lim);
        return (v > lim) ? lim : v;
    endfunction

    // signed area of (a, b, p), sign tells the side of edge a->b
    function automatic logic signed [11:0] edge_fn(input raster_pkg::vertex_t a,
                                                   input raster_pkg::vertex_t b,
                                                   input logic [`COORD_W-1:0] qx,
                                                   input logic [`COORD_W-1:0] qy);
        logic signed [11:0] ax, ay, bx, by, sx, sy;
        ax = {{(12-`COORD_W){1'b0}}, a.x};
        ay = {{(12-`COORD_W){1'b0}}, a.y};
        bx = {{(12-`COORD_W){1'b0}}, b.x};
        by = {{(12-`COORD_W){1'b0}}, b.y};
        sx = {{(12-`COORD_W){1'b0}}, qx};
        sy = {{(12-`COORD_W){1'b0}}, qy};
        return (bx - ax) * (sy - ay) - (by - ay) * (sx - ax);
    endfunction

    localparam logic [`COORD_W-1:0] X_LAST = `COORD_W'(`SCREEN_W - 1);
    localparam logic [`COORD_W-1:0] Y_LAST = `COORD_W'(`SCREEN_H - 1);

    assign start_clr = (state == ST_IDLE) && i_clear;
    assign start_tri = (state == ST_IDLE) && !i_clear && i_tri_valid;

    always_comb begin
        e0 = edge_fn(tri_q.v0, tri_q.v1, px, py);
        e1 = edge_fn(tri_q.v1, tri_q.v2, px, py);
        e2 = edge_fn(tri_q.v2, tri_q.v0, px, py);
        // either winding, edges inclusive
        covered = (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
    end

    assign last_px = (px == xmax) && (py == ymax);
    assign step = (state == ST_SCAN && !covered)
               || (state == ST_CMP && !(tri_q.depth < i_rdata.depth))
               || (state == ST_WRITE && i_gnt);

    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            state  <= ST_IDLE;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_clr) state <= ST_CLEAR;
                    else if (start_tri) state <= ST_SCAN;
                end
                ST_CLEAR: begin
                    if (i_gnt && clr_addr == `FB_AW'(`FB_DEPTH - 1)) begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;
                    end
                end
                ST_SCAN: if (covered) state <= ST_READ;
                ST_READ: if (i_gnt) state <= ST_CMP;  // data arrives next cycle
                ST_CMP:  if (tri_q.depth < i_rdata.depth) state <= ST_WRITE;
                default: ;
            endcase
            if (step) begin
                if (last_px) begin
                    state  <= ST_IDLE;
                    o_done <= 1'b1;
                end else begin
                    state <= ST_SCAN;
                end
            end
        end
    end

    // triangle, box and walk counters
    always_ff @(posedge clk_pix) begin
        if (start_clr) clr_addr <= '0;
        else if (state == ST_CLEAR && i_gnt) clr_addr <= clr_addr + 1'b1;

        if (start_tri) begin
            tri_q <= i_tri;
            xmin  <= clip(lo3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x), X_LAST);
            xmax  <= clip(hi3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x), X_LAST);
            ymax  <= clip(hi3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y), Y_LAST);
            px    <= clip(lo3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x), X_LAST);
            py    <= clip(lo3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y), Y_LAST);
        end else if (step && !last_px) begin
            if (px == xmax) begin
                px <= xmin;       // next row
                py <= py + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
    end

    always_comb begin
        o_req.valid = (state == ST_CLEAR) || (state == ST_READ) || (state == ST_WRITE);
        o_req.write = (state != ST_READ);
        if (state == ST_CLEAR) begin
            o_req.addr       = clr_addr;
            o_req.data.depth = 8'(`DEPTH_FAR);
            o_req.data.color = 4'(`BG_INDEX);
        end else begin
            o_req.addr       = `FB_AW'(py * `SCREEN_W + px);
            o_req.data.depth = tri_q.depth;
            o_req.data.color = tri_q.color;
        end
    end

    assign o_busy = (state != ST_IDLE);

endmodule

// File: display/scan_timing.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module scan_timing (
    input  logic                clk_pix,
    input  logic                i_rst_n,
    output logic [`COORD_W-1:0] o_x,
    output logic [`COORD_W-1:0] o_y,
    output logic                o_de,
    output logic                o_frame
);

    localparam logic [`COORD_W-1:0] X_END = `COORD_W'(`LINE_TOTAL - 1);
    localparam logic [`COORD_W-1:0] Y_END = `COORD_W'(`FRAME_LINES - 1);

    logic line_end;

    assign line_end = (o_x == X_END);

    // beam counters, one pixel per clock
    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            o_x <= '0;
            o_y <= '0;
        end else if (line_end) begin
            o_x <= '0;
            if (o_y == Y_END) begin
                o_y <= '0;
            end else begin
                o_y <= o_y + 1'b1;
            end
        end else begin
            o_x <= o_x + 1'b1;
        end
    end

    // visible area in the top left corner
    assign o_de = (o_x < `COORD_W'(`SCREEN_W)) && (o_y < `COORD_W'(`SCREEN_H));

    assign o_frame = (o_x == '0) && (o_y == '0);  // start of frame

endmodule

// File: display/pixel_out.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module pixel_out (
    input  logic                 clk_pix,
    input  logic                 i_rst_n,
    input  logic [`COORD_W-1:0]  i_x,
    input  logic [`COORD_W-1:0]  i_y,
    input  logic                 i_de,
    input  logic                 i_frame,
    input  raster_pkg::fb_word_t i_rdata,
    output raster_pkg::fb_req_t  o_req,
    output logic [`COORD_W-1:0]  o_sx,
    output logic [`COORD_W-1:0]  o_sy,
    output logic                 o_de,
    output logic                 o_frame,
    output logic [7:0]           o_r,
    output logic [7:0]           o_g,
    output logic [7:0]           o_b
);

    logic [`COORD_W-1:0] sx_q, sy_q;  // beam while memory reads
    logic                de_q, frame_q;
    logic [3:0]          idx;

    // read the word under the beam during active video
    always_comb begin
        o_req.valid = i_de;
        o_req.write = 1'b0;
        o_req.addr  = `FB_AW'(i_y * `SCREEN_W + i_x);
        o_req.data  = '0;
    end

    always_ff @(posedge clk_pix) begin
        sx_q <= i_x;
        sy_q <= i_y;
        o_sx <= sx_q;
        o_sy <= sy_q;
    end

    assign idx = i_rdata.color;

    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            de_q    <= 1'b0;
            frame_q <= 1'b0;
            o_de    <= 1'b0;
            o_frame <= 1'b0;
            o_r     <= '0;
            o_g     <= '0;
            o_b     <= '0;
        end else begin
            de_q    <= i_de;
            frame_q <= i_frame;
            o_de    <= de_q;
            o_frame <= frame_q;
            if (de_q) begin
                o_r <= {2{idx}};             // palette red
                o_g <= {2{4'd15 - idx}};
                o_b <= {2{idx ^ 4'd5}};
            end else begin
                o_r <= '0;                   // black in blanking
                o_g <= '0;
                o_b <= '0;
            end
        end
    end

endmodule

// File: logic/raster_top.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module raster_top (
    input  logic                clk_pix,
    input  logic                i_rst_n,
    input  raster_pkg::tri_t    i_tri,
    input  logic                i_tri_valid,
    input  logic                i_clear,
    output logic                o_busy,
    output logic                o_done,
    output logic [`COORD_W-1:0] o_sx,
    output logic [`COORD_W-1:0] o_sy,
    output logic                o_de,
    output logic                o_frame,
    output logic [7:0]          o_r,
    output logic [7:0]          o_g,
    output logic [7:0]          o_b
);

    raster_pkg::fb_req_t  r_req, d_req, mem_req;
    raster_pkg::fb_word_t rdata;
    logic                 r_gnt, d_gnt;
    logic [`COORD_W-1:0]  beam_x, beam_y;
    logic                 beam_de, beam_frame;

    tri_rasterizer raster_i (
        .clk_pix     (clk_pix),
        .i_rst_n     (i_rst_n),
        .i_tri       (i_tri),
        .i_tri_valid (i_tri_valid),
        .i_clear     (i_clear),
        .i_gnt       (r_gnt),
        .i_rdata     (rdata),
        .o_req       (r_req),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    scan_timing timing_i (
        .clk_pix (clk_pix),
        .i_rst_n (i_rst_n),
        .o_x     (beam_x),
        .o_y     (beam_y),
        .o_de    (beam_de),
        .o_frame (beam_frame)
    );

    pixel_out pixel_i (
        .clk_pix (clk_pix),
        .i_rst_n (i_rst_n),
        .i_x     (beam_x),
        .i_y     (beam_y),
        .i_de    (beam_de),
        .i_frame (beam_frame),
        .i_rdata (rdata),
        .o_req   (d_req),
        .o_sx    (o_sx),
        .o_sy    (o_sy),
        .o_de    (o_de),
        .o_frame (o_frame),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b)
    );

    // display wins the shared port
    fb_arbiter arb_i (
        .clk_pix   (clk_pix),
        .i_rst_n   (i_rst_n),
        .i_d_req   (d_req),
        .i_r_req   (r_req),
        .o_mem_req (mem_req),
        .o_d_gnt   (d_gnt),
        .o_r_gnt   (r_gnt)
    );

    framebuffer_ram fb_i (
        .clk_pix (clk_pix),
        .i_req   (mem_req),
        .o_rdata (rdata)
    );

endmodule

// File: verif/raster_checker.sv
`timescale 1ns/10ps

module raster_checker (
    input logic                clk_pix,
    input logic                i_rst_n,
    input raster_pkg::fb_req_t i_d_req,
    input logic                i_d_gnt,
    input logic                i_r_gnt,
    input logic                i_busy,
    input logic                i_done
);

    // only one owner of the framebuffer port per cycle
    a_one_grant: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        !(i_d_gnt && i_r_gnt))
        else $error("display and rasterizer granted in the same cycle");

    a_disp_first: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_d_req.valid |-> !i_r_gnt)  // display priority
        else $error("rasterizer granted while the display requests");

    a_done_pulse: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_done |-> !$past(i_done))
        else $error("o_done high for more than one cycle");

    a_done_fall: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_done |-> $fell(i_busy))
        else $error("o_done without o_busy falling");

endmodule

// arbiter grants and rasterizer status are all visible in the top level
bind raster_top raster_checker chk_i (
    .clk_pix (clk_pix),
    .i_rst_n (i_rst_n),
    .i_d_req (d_req),
    .i_d_gnt (d_gnt),
    .i_r_gnt (r_gnt),
    .i_busy  (o_busy),
    .i_done  (o_done)
);

// File: verif/raster_tb.sv
`timescale 1ns/10ps

`include "raster_macros.svh"

module raster_tb;

    localparam logic [1:0] K_CLEAR = 2'd0;
    localparam logic [1:0] K_TRI   = 2'd1;
    localparam logic [1:0] K_BUSY  = 2'd2;  // second strobe lands while busy
    localparam logic [1:0] K_FRAME = 2'd3;
    localparam int FRAME_CYCLES = `LINE_TOTAL * `FRAME_LINES;
    localparam int DONE_TIMEOUT = 20000;
    localparam raster_pkg::tri_t NO_TRI = '0;

    typedef struct packed {
        logic [1:0]       kind;
        logic [3:0]       beh;     // behavior number for error lines
        raster_pkg::tri_t tri_a;
        raster_pkg::tri_t tri_b;   // dropped triangle of a busy step
    } step_t;

    logic                clk_pix = 1'b0;
    logic                i_rst_n;
    raster_pkg::tri_t    i_tri;
    logic                i_tri_valid;
    logic                i_clear;
    logic                o_busy, o_done, o_de, o_frame;
    logic [`COORD_W-1:0] o_sx, o_sy;
    logic [7:0]          o_r, o_g, o_b;

    step_t      steps[$];
    int         ref_depth [`FB_DEPTH];   // reference framebuffer
    int         ref_color [`FB_DEPTH];
    int         errors = 0;
    logic [3:0] rand_color;

    always #2 clk_pix = ~clk_pix;

    raster_top dut_i (
        .clk_pix     (clk_pix),
        .i_rst_n     (i_rst_n),
        .i_tri       (i_tri),
        .i_tri_valid (i_tri_valid),
        .i_clear     (i_clear),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_sx        (o_sx),
        .o_sy        (o_sy),
        .o_de        (o_de),
        .o_frame     (o_frame),
        .o_r         (o_r),
        .o_g         (o_g),
        .o_b         (o_b)
    );

    task automatic fail_and_stop;
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    function automatic raster_pkg::tri_t make_tri(input int x0, input int y0, input int x1,
                                                  input int y1, input int x2, input int y2,
                                                  input int depth, input int color);
        raster_pkg::tri_t t;
        t.v0.x  = `COORD_W'(x0);
        t.v0.y  = `COORD_W'(y0);
        t.v1.x  = `COORD_W'(x1);
        t.v1.y  = `COORD_W'(y1);
        t.v2.x  = `COORD_W'(x2);
        t.v2.y  = `COORD_W'(y2);
        t.depth = 8'(depth);
        t.color = 4'(color);
        return t;
    endfunction

    // cross product of (a - p) and (b - p)
    function automatic int side(input raster_pkg::vertex_t a, input raster_pkg::vertex_t b,
                                input int px, input int py);
        return (int'(a.x) - px) * (int'(b.y) - py) - (int'(a.y) - py) * (int'(b.x) - px);
    endfunction

    function automatic bit covers(input raster_pkg::tri_t t, input int px, input int py);
        int w0, w1, w2;
        w0 = side(t.v0, t.v1, px, py);
        w1 = side(t.v1, t.v2, px, py);
        w2 = side(t.v2, t.v0, px, py);
        return (w0 >= 0 && w1 >= 0 && w2 >= 0) || (w0 <= 0 && w1 <= 0 && w2 <= 0);
    endfunction

    // a nibble shown in both halves of a byte is the nibble times 17
    function automatic logic [23:0] palette_rgb(input int idx);
        int r, g, b;
        r = idx * 17;
        g = (15 - idx) * 17;
        b = (idx ^ 5) * 17;
        return {8'(r), 8'(g), 8'(b)};
    endfunction

    task automatic draw_ref(input raster_pkg::tri_t t);
        int a;
        for (int y = 0; y < `SCREEN_H; y++) begin
            for (int x = 0; x < `SCREEN_W; x++) begin
                a = y * `SCREEN_W + x;
                if (covers(t, x, y) && int'(t.depth) < ref_depth[a]) begin
                    ref_depth[a] = int'(t.depth);
                    ref_color[a] = int'(t.color);
                end
            end
        end
    endtask

    task automatic clear_ref;
        for (int a = 0; a < `FB_DEPTH; a++) begin
            ref_depth[a] = `DEPTH_FAR;
            ref_color[a] = `BG_INDEX;
        end
    endtask

    function automatic void add_step(input logic [1:0] kind, input int beh,
                                     input raster_pkg::tri_t a, input raster_pkg::tri_t b);
        step_t s;
        s.kind  = kind;
        s.beh   = 4'(beh);
        s.tri_a = a;
        s.tri_b = b;
        steps.push_back(s);
    endfunction

    task automatic build_table;
        raster_pkg::tri_t far_t, near_t, same_t;
        far_t  = make_tri(0, 0, 10, 0, 0, 10, 200, 6);
        near_t = make_tri(4, 2, 14, 4, 6, 11, 50, 9);
        same_t = make_tri(2, 2, 13, 3, 8, 11, 200, 12);  // ties with far_t
        add_step(K_CLEAR, 1, NO_TRI, NO_TRI);
        add_step(K_FRAME, 1, NO_TRI, NO_TRI);
        add_step(K_TRI,   2, make_tri(2, 1, 3, 9, 12, 6, 100, 3), NO_TRI);
        add_step(K_FRAME, 2, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 3, NO_TRI, NO_TRI);
        add_step(K_TRI,   3, make_tri(2, 1, 12, 6, 3, 9, 100, 3), NO_TRI);  // other winding
        add_step(K_FRAME, 3, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 4, NO_TRI, NO_TRI);
        add_step(K_TRI,   4, far_t, NO_TRI);
        add_step(K_TRI,   4, near_t, NO_TRI);
        add_step(K_FRAME, 4, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 4, NO_TRI, NO_TRI);
        add_step(K_TRI,   4, near_t, NO_TRI);
        add_step(K_TRI,   4, far_t, NO_TRI);
        add_step(K_FRAME, 4, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 4, NO_TRI, NO_TRI);
        add_step(K_TRI,   4, far_t, NO_TRI);
        add_step(K_TRI,   4, same_t, NO_TRI);
        add_step(K_FRAME, 4, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 5, NO_TRI, NO_TRI);
        add_step(K_TRI,   5, make_tri(8, 5, 30, 7, 12, 25, 60, 10), NO_TRI);
        add_step(K_TRI,   5, make_tri(20, 2, 1, 11, 31, 28, 40, int'(rand_color)), NO_TRI);
        add_step(K_FRAME, 5, NO_TRI, NO_TRI);
        add_step(K_CLEAR, 6, NO_TRI, NO_TRI);
        add_step(K_BUSY,  6, make_tri(0, 0, 15, 1, 2, 11, 120, 5),
                 make_tri(3, 3, 13, 5, 5, 10, 10, 14));
        add_step(K_FRAME, 6, NO_TRI, NO_TRI);
    endtask

    task automatic strobe_clear;
        @(posedge clk_pix);
        i_clear <= 1'b1;
        @(posedge clk_pix);
        i_clear <= 1'b0;
    endtask

    task automatic strobe_tri(input raster_pkg::tri_t t);
        @(posedge clk_pix);
        i_tri       <= t;
        i_tri_valid <= 1'b1;
        @(posedge clk_pix);
        i_tri_valid <= 1'b0;
    endtask

    task automatic wait_done;
        int n;
        n = 0;
        @(negedge clk_pix);
        while (!o_done) begin
            n++;
            if (n > DONE_TIMEOUT) begin
                $display("timeout: the rasterizer never raised o_done");
                fail_and_stop();
            end
            @(negedge clk_pix);
        end
    endtask

    task automatic wait_busy;
        int n;
        n = 0;
        @(negedge clk_pix);
        while (!o_busy) begin
            n++;
            if (n > 50) begin
                $display("timeout: the rasterizer never raised o_busy");
                fail_and_stop();
            end
            @(negedge clk_pix);
        end
    endtask

    // one whole frame from the start pulse, compared against the model
    task automatic capture_frame(input int beh);
        int          n, a, x, y;
        logic        vis;
        logic [23:0] want;
        n = 0;
        @(negedge clk_pix);
        while (!o_frame) begin
            n++;
            if (n > 2 * FRAME_CYCLES) begin
                $display("timeout: no frame pulse on the display outputs");
                fail_and_stop();
            end
            @(negedge clk_pix);
        end
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) @(negedge clk_pix);
            x   = i % `LINE_TOTAL;   // beam position the outputs should show
            y   = i / `LINE_TOTAL;
            vis = (x < `SCREEN_W) && (y < `SCREEN_H);
            check_value($sformatf("b%0d sx x%0d y%0d", beh, x, y), 32'(x), 32'(o_sx));
            check_value($sformatf("b%0d sy x%0d y%0d", beh, x, y), 32'(y), 32'(o_sy));
            check_value($sformatf("b%0d de x%0d y%0d", beh, x, y), 32'(vis), 32'(o_de));
            check_value($sformatf("b%0d frame x%0d y%0d", beh, x, y),
                        32'(i == 0), 32'(o_frame));
            if (vis) begin
                a    = y * `SCREEN_W + x;
                want = palette_rgb(ref_color[a]);
            end else begin
                want = '0;   // black in blanking
            end
            check_value($sformatf("b%0d rgb x%0d y%0d", beh, x, y),
                        32'(want), 32'({o_r, o_g, o_b}));
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_tri       = '0;
        i_tri_valid = 1'b0;
        i_clear     = 1'b0;
        void'($urandom(32'h83f1_6452));
        rand_color = 4'($urandom());
        build_table();
        repeat (2) @(posedge clk_pix);
        i_rst_n <= 1'b1;
        @(negedge clk_pix);
        check_value("b1 reset o_busy", 32'd0, 32'(o_busy));
        check_value("b1 reset o_done", 32'd0, 32'(o_done));
        check_value("b1 reset o_de", 32'd0, 32'(o_de));
        foreach (steps[i]) begin
            case (steps[i].kind)
                K_CLEAR: begin
                    strobe_clear();
                    wait_done();
                    clear_ref();
                end
                K_TRI: begin
                    strobe_tri(steps[i].tri_a);
                    wait_done();
                    draw_ref(steps[i].tri_a);
                end
                K_BUSY: begin
                    strobe_tri(steps[i].tri_a);
                    wait_busy();
                    strobe_tri(steps[i].tri_b);  // must be dropped
                    wait_done();
                    draw_ref(steps[i].tri_a);
                    repeat (4) @(negedge clk_pix);
                    check_value("b6 o_busy after done", 32'd0, 32'(o_busy));
                end
                default: capture_frame(int'(steps[i].beh));
            endcase
        end
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

endmodule

// File: project.f
+incdir+common
common/raster_pkg.sv
logic/framebuffer_ram.sv
logic/fb_arbiter.sv
raster/tri_rasterizer.sv
display/scan_timing.sv
display/pixel_out.sv
logic/raster_top.sv
verif/raster_checker.sv
verif/raster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the rasterizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

verilator --binary --timing --assert -f project.f --top-module raster_tb \
    -Mdir "$obj_dir" -o Vraster_tb
if [ $? -ne 0 ]; then
    echo "RESULT: build failed"
    exit 1
fi

"./$obj_dir/Vraster_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# testbench verdict from the log
if grep -q "Something failed" "$log_file"; then
    echo "RESULT: FAIL"
    exit 1
fi

# assertion stops or crashes leave no verdict line
if [ $run_status -ne 0 ] || ! grep -q "Everything OK" "$log_file"; then
    echo "RESULT: FAIL (simulator exit status $run_status)"
    exit 1
fi

echo "RESULT: PASS"
exit 0
